/* hw/dcp_cmd_pkg.sv */
package dcp_cmd_pkg;

    // command letters as they arrive on the byte stream
    typedef enum logic [7:0] {
        CMD_D = 8'h44,
        CMD_I = 8'h49,
        CMD_P = 8'h50,
        CMD_R = 8'h52,
        CMD_T = 8'h54
    } cmd_e;

    typedef enum logic [1:0] {
        IDLE,
        GET_CMD,
        RUN,
        REJECT
    } ctrl_state_e;

    typedef enum logic {SCAN_CHAR, SCAN_WORD} scan_kind_e;
    typedef enum logic {PRINT_CHAR, PRINT_WORD} print_kind_e;

    typedef struct packed {
        logic       req;
        scan_kind_e kind;
    } rx_req_t;

    typedef struct packed {
        logic        ack;
        logic        err;   // bad or missing hex digit
        logic [31:0] data;
    } rx_rsp_t;

    typedef struct packed {
        logic        req;
        print_kind_e kind;
        logic [31:0] data;
    } tx_req_t;

    localparam logic [7:0] CHR_NL = 8'h0A;
    localparam logic [7:0] CHR_SP = 8'h20;
    localparam logic [7:0] CHR_QM = 8'h3F;

    localparam int HEX_DIGITS = 8;   // nibbles per word

endpackage

/* hw/dcp_cpu_pkg.sv */
package dcp_cpu_pkg;

    // which memory a read command looks at
    typedef enum logic [1:0] {
        SPACE_DM,
        SPACE_IM,
        SPACE_RF
    } mem_space_e;

    // processor state visible to the panel
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] ir;
    } cpu_view_t;

    // read words for the current addr, one per space
    typedef struct packed {
        logic [31:0] dm;
        logic [31:0] im;
        logic [31:0] rf;
    } mem_rd_t;

endpackage

/* hw/dcp_scan.sv */
module dcp_scan (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic [7:0]           d_rx,
    input  logic                 vld_rx,
    output logic                 rdy_rx,
    input  dcp_cmd_pkg::rx_req_t rx_req,
    output dcp_cmd_pkg::rx_rsp_t rx_rsp
);
    import dcp_cmd_pkg::*;

    typedef enum logic [1:0] {SC_SKIP, SC_WORD, SC_BAD} scan_state_e;

    scan_state_e state;
    logic [31:0] acc;
    logic        xfer;
    logic        word_xfer;
    logic        is_hex;
    logic [3:0]  nib;
    logic        is_delim;
    logic        lead_sp;

    assign rdy_rx    = rx_req.req;
    assign xfer      = vld_rx && rx_req.req;
    assign word_xfer = xfer && (rx_req.kind == SCAN_WORD);
    assign is_delim  = (d_rx == CHR_SP) || (d_rx == CHR_NL);
    assign lead_sp   = (state == SC_SKIP) && (d_rx == CHR_SP);

    // ascii to nibble
    always_comb begin
        is_hex = 1'b1;
        nib    = d_rx[3:0];
        if ((d_rx >= 8'h41 && d_rx <= 8'h46) || (d_rx >= 8'h61 && d_rx <= 8'h66))
            nib = d_rx[3:0] + 4'd9;   // 'A' and 'a' end in 1
        else if (d_rx < 8'h30 || d_rx > 8'h39)
            is_hex = 1'b0;
    end

    always_comb begin
        rx_rsp = '0;
        if (xfer) begin
            if (rx_req.kind == SCAN_CHAR) begin
                rx_rsp.ack  = 1'b1;
                rx_rsp.data = {24'h0, d_rx};
            end else if (is_delim && !lead_sp) begin
                rx_rsp.ack = 1'b1;
                if (state == SC_WORD)
                    rx_rsp.data = acc;
                else
                    rx_rsp.err = 1'b1;   // empty or poisoned word
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= SC_SKIP;
        end else if (rx_rsp.ack) begin
            state <= SC_SKIP;
        end else if (word_xfer) begin
            case (state)
                SC_SKIP: begin
                    if (is_hex)
                        state <= SC_WORD;
                    else if (d_rx != CHR_SP)
                        state <= SC_BAD;
                end
                SC_WORD: if (!is_hex) state <= SC_BAD;
                default: state <= SC_BAD;   // swallow up to the delimiter
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (word_xfer && is_hex)
            acc <= (state == SC_SKIP) ? {28'h0, nib} : {acc[27:0], nib};
    end

endmodule

/* hw/dcp_print.sv */
module dcp_print (
    input  logic                 clk,
    input  logic                 rstn,
    output logic [7:0]           d_tx,
    output logic                 vld_tx,
    input  logic                 rdy_tx,
    input  dcp_cmd_pkg::tx_req_t tx_req,
    output logic                 tx_ack
);
    import dcp_cmd_pkg::*;

    logic        busy;
    print_kind_e kind;
    logic [31:0] sreg;
    logic [3:0]  cnt;   // digits already sent
    logic        last;
    logic        xfer;

    function automatic logic [7:0] hex_char(input logic [3:0] n);
        if (n < 4'd10)
            return 8'h30 + {4'h0, n};
        return 8'h37 + {4'h0, n};   // 'A' - 10
    endfunction

    assign vld_tx = busy;
    assign xfer   = busy && rdy_tx;
    assign last   = (kind == PRINT_CHAR) || (cnt == 4'(HEX_DIGITS));
    assign tx_ack = xfer && last;

    always_comb begin
        if (kind == PRINT_CHAR)
            d_tx = sreg[7:0];
        else if (cnt == 4'(HEX_DIGITS))
            d_tx = CHR_NL;
        else
            d_tx = hex_char(sreg[31:28]);
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy <= 1'b0;
            cnt  <= 4'd0;
        end else if (!busy) begin
            if (tx_req.req) begin
                busy <= 1'b1;
                cnt  <= 4'd0;
            end
        end else if (xfer) begin
            if (last)
                busy <= 1'b0;
            else
                cnt <= cnt + 4'd1;
        end
    end

    // msb nibble goes first
    always_ff @(posedge clk) begin
        if (!busy && tx_req.req) begin
            sreg <= tx_req.data;
            kind <= tx_req.kind;
        end else if (xfer) begin
            sreg <= {sreg[27:0], 4'h0};
        end
    end

endmodule

/* hw/dcp_ctrl.sv */
module dcp_ctrl (
    input  logic                    clk,
    input  logic                    rstn,
    input  dcp_cmd_pkg::rx_rsp_t    rx_rsp,
    output dcp_cmd_pkg::rx_req_t    rx_req,
    input  logic                    tx_ack,
    output dcp_cmd_pkg::tx_req_t    tx_req,
    output logic                    mem_start,
    output logic                    step_start,
    output logic                    step,
    output dcp_cpu_pkg::mem_space_e space,
    input  logic                    mem_done,
    input  logic                    step_done,
    input  dcp_cmd_pkg::rx_req_t    mem_rx_req,
    input  dcp_cmd_pkg::tx_req_t    mem_tx_req,
    input  dcp_cmd_pkg::tx_req_t    step_tx_req
);
    import dcp_cmd_pkg::*;
    import dcp_cpu_pkg::*;

    ctrl_state_e state;
    cmd_e        cmd;
    logic        sel_mem;   // memory handler owns the links
    logic        rej_nl;
    logic        blank;
    logic        got_cmd;

    assign cmd     = cmd_e'(rx_rsp.data[7:0]);
    assign blank   = (rx_rsp.data[7:0] == CHR_SP) || (rx_rsp.data[7:0] == CHR_NL);
    assign got_cmd = (state == GET_CMD) && rx_rsp.ack && !blank;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= IDLE;
            sel_mem    <= 1'b0;
            rej_nl     <= 1'b0;
            mem_start  <= 1'b0;
            step_start <= 1'b0;
        end else begin
            mem_start  <= 1'b0;
            step_start <= 1'b0;
            case (state)
                IDLE: state <= GET_CMD;
                GET_CMD: begin
                    if (got_cmd) begin
                        case (cmd)
                            CMD_D, CMD_I, CMD_R: begin
                                sel_mem   <= 1'b1;
                                mem_start <= 1'b1;
                                state     <= RUN;
                            end
                            CMD_P, CMD_T: begin
                                sel_mem    <= 1'b0;
                                step_start <= 1'b1;
                                state      <= RUN;
                            end
                            default: state <= REJECT;
                        endcase
                    end
                end
                RUN: if (sel_mem ? mem_done : step_done) state <= IDLE;
                REJECT: begin
                    if (tx_ack) begin
                        rej_nl <= !rej_nl;
                        if (rej_nl)
                            state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // held for the whole command
    always_ff @(posedge clk) begin
        if (got_cmd) begin
            step <= (cmd == CMD_T);
            case (cmd)
                CMD_I:   space <= SPACE_IM;
                CMD_R:   space <= SPACE_RF;
                default: space <= SPACE_DM;
            endcase
        end
    end

    always_comb begin
        rx_req = '0;
        tx_req = '0;
        case (state)
            GET_CMD: begin
                rx_req.req  = 1'b1;
                rx_req.kind = SCAN_CHAR;
            end
            RUN: begin
                if (sel_mem) begin
                    rx_req = mem_rx_req;
                    tx_req = mem_tx_req;
                end else begin
                    tx_req = step_tx_req;
                end
            end
            REJECT: begin
                tx_req.req  = 1'b1;
                tx_req.kind = PRINT_CHAR;
                tx_req.data = {24'h0, rej_nl ? CHR_NL : CHR_QM};
            end
            default: ;
        endcase
    end

endmodule

/* hw/dcp_cmd_mem.sv */
module dcp_cmd_mem (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    start,
    input  dcp_cpu_pkg::mem_space_e space,
    output logic                    done,
    output dcp_cmd_pkg::rx_req_t    rx_req,
    input  dcp_cmd_pkg::rx_rsp_t    rx_rsp,
    output dcp_cmd_pkg::tx_req_t    tx_req,
    input  logic                    tx_ack,
    output logic [31:0]             addr,
    input  dcp_cpu_pkg::mem_rd_t    mem
);
    import dcp_cmd_pkg::*;
    import dcp_cpu_pkg::*;

    typedef enum logic [2:0] {M_IDLE, M_SCAN, M_READ, M_PRINT, M_QM, M_NL} mem_state_e;

    mem_state_e  state;
    logic [31:0] rd_word;
    logic [31:0] word;

    always_comb begin
        case (space)
            SPACE_IM: rd_word = mem.im;
            SPACE_RF: rd_word = mem.rf;
            default:  rd_word = mem.dm;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= M_IDLE;
            addr  <= 32'h0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                M_IDLE: if (start) state <= M_SCAN;
                M_SCAN: begin
                    if (rx_rsp.ack) begin
                        if (rx_rsp.err) begin
                            state <= M_QM;
                        end else begin
                            addr  <= rx_rsp.data;
                            state <= M_READ;
                        end
                    end
                end
                M_READ:  state <= M_PRINT;   // read word lands this cycle
                M_QM:    if (tx_ack) state <= M_NL;
                default: begin
                    if (tx_ack) begin
                        done  <= 1'b1;
                        state <= M_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == M_READ)
            word <= rd_word;
    end

    always_comb begin
        rx_req.req  = (state == M_SCAN);
        rx_req.kind = SCAN_WORD;
        tx_req      = '0;
        case (state)
            M_PRINT: tx_req = '{req: 1'b1, kind: PRINT_WORD, data: word};
            M_QM:    tx_req = '{req: 1'b1, kind: PRINT_CHAR, data: {24'h0, CHR_QM}};
            M_NL:    tx_req = '{req: 1'b1, kind: PRINT_CHAR, data: {24'h0, CHR_NL}};
            default: ;
        endcase
    end

endmodule

/* hw/dcp_cmd_step.sv */
module dcp_cmd_step (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   start,
    input  logic                   step,
    output logic                   done,
    output dcp_cmd_pkg::tx_req_t   tx_req,
    input  logic                   tx_ack,
    output logic                   clk_cpu,
    input  dcp_cpu_pkg::cpu_view_t cpu
);
    import dcp_cmd_pkg::*;

    typedef enum logic [2:0] {ST_IDLE, ST_PULSE, ST_SETTLE, ST_PC, ST_IR} step_state_e;

    step_state_e state;
    logic        settle;   // second cycle after the falling edge
    logic        grab;
    logic [31:0] pc_q;
    logic [31:0] ir_q;

    assign grab = ((state == ST_IDLE) && start && !step) || ((state == ST_SETTLE) && settle);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= ST_IDLE;
            clk_cpu <= 1'b0;
            settle  <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        clk_cpu <= step;
                        state   <= step ? ST_PULSE : ST_PC;
                    end
                end
                ST_PULSE: begin
                    clk_cpu <= 1'b0;   // one clk cycle high
                    settle  <= 1'b0;
                    state   <= ST_SETTLE;
                end
                ST_SETTLE: begin
                    settle <= 1'b1;
                    if (settle)
                        state <= ST_PC;
                end
                ST_PC: begin
                    if (tx_ack) begin
                        done  <= step;
                        state <= step ? ST_IDLE : ST_IR;
                    end
                end
                default: begin
                    if (tx_ack) begin
                        done  <= 1'b1;
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (grab) begin
            pc_q <= cpu.pc;
            ir_q <= cpu.ir;
        end
    end

    always_comb begin
        tx_req      = '0;
        tx_req.kind = PRINT_WORD;
        if (state == ST_PC) begin
            tx_req.req  = 1'b1;
            tx_req.data = pc_q;
        end else if (state == ST_IR) begin
            tx_req.req  = 1'b1;
            tx_req.data = ir_q;
        end
    end

endmodule

/* hw/dcp_top.sv */
module dcp_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [7:0]             d_rx,
    input  logic                   vld_rx,
    output logic                   rdy_rx,
    output logic [7:0]             d_tx,
    output logic                   vld_tx,
    input  logic                   rdy_tx,
    input  dcp_cpu_pkg::cpu_view_t cpu,
    input  dcp_cpu_pkg::mem_rd_t   mem,
    output logic [31:0]            addr,
    output logic                   clk_cpu
);
    import dcp_cmd_pkg::*;
    import dcp_cpu_pkg::*;

    rx_req_t    rx_req;
    rx_req_t    mem_rx_req;
    rx_rsp_t    rx_rsp;
    tx_req_t    tx_req;
    tx_req_t    mem_tx_req;
    tx_req_t    step_tx_req;
    logic       tx_ack;
    logic       mem_start;
    logic       mem_done;
    logic       step_start;
    logic       step_done;
    logic       step;
    mem_space_e space;

    dcp_scan scan0 (.clk(clk), .rstn(rstn), .d_rx(d_rx), .vld_rx(vld_rx), .rdy_rx(rdy_rx),
        .rx_req(rx_req), .rx_rsp(rx_rsp));

    dcp_print print0 (.clk(clk), .rstn(rstn), .d_tx(d_tx), .vld_tx(vld_tx), .rdy_tx(rdy_tx),
        .tx_req(tx_req), .tx_ack(tx_ack));

    dcp_ctrl ctrl0 (.clk(clk), .rstn(rstn), .rx_rsp(rx_rsp), .rx_req(rx_req),
        .tx_ack(tx_ack), .tx_req(tx_req), .mem_start(mem_start), .step_start(step_start),
        .step(step), .space(space), .mem_done(mem_done), .step_done(step_done),
        .mem_rx_req(mem_rx_req), .mem_tx_req(mem_tx_req), .step_tx_req(step_tx_req));

    // D, I and R
    dcp_cmd_mem mem0 (.clk(clk), .rstn(rstn), .start(mem_start), .space(space),
        .done(mem_done), .rx_req(mem_rx_req), .rx_rsp(rx_rsp), .tx_req(mem_tx_req),
        .tx_ack(tx_ack), .addr(addr), .mem(mem));

    // P and T
    dcp_cmd_step step0 (.clk(clk), .rstn(rstn), .start(step_start), .step(step),
        .done(step_done), .tx_req(step_tx_req), .tx_ack(tx_ack), .clk_cpu(clk_cpu),
        .cpu(cpu));

endmodule

/* test/tb_clkgen.sv */
module tb_clkgen (
    output logic clk,
    output logic rstn
);
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (4) @(posedge clk);
        #1 rstn = 1'b1;   // released just after the 4th edge
    end

endmodule

/* test/tb_dcp.sv */
module tb_dcp;
    import dcp_cmd_pkg::*;
    import dcp_cpu_pkg::*;

    localparam logic [31:0] SEED = 32'h6303a59e;
    localparam logic [31:0] TAPS = 32'h8020_0003;
    localparam int N_TESTS     = 5;
    localparam int N_CMDS      = 15 + 2 + 6 + 4 + 40;   // commands over all tests
    localparam int WORST_BYTES = 32;   // 14 in, 18 out for P
    localparam int MAX_STALL   = 8;
    localparam int DRAIN_CYCLES = 32;   // quiet time after the last reply
    localparam int TIMEOUT_CYCLES = N_CMDS * WORST_BYTES * MAX_STALL
        + N_TESTS * DRAIN_CYCLES + 1000;

    logic        clk, rstn;
    logic [7:0]  d_rx, d_tx;
    logic        vld_rx, rdy_rx, vld_tx, rdy_tx;
    cpu_view_t   cpu;
    mem_rd_t     mem;
    logic [31:0] addr;
    logic        clk_cpu;
    logic [31:0] cpu_pc;
    logic [31:0] lfsr;
    logic [31:0] stall_r;
    logic        stall_en;
    logic [31:0] exp_pc;
    string       exp_q[$];
    string       name_q[$];
    string       line = "";
    string       test_name;
    int          n_checks = 0;
    int          n_errors = 0;
    int          chk0, err0;
    int          cycles = 0;

    tb_clkgen clkgen0 (.clk(clk), .rstn(rstn));

    dcp_top dut0 (.clk(clk), .rstn(rstn), .d_rx(d_rx), .vld_rx(vld_rx), .rdy_rx(rdy_rx),
        .d_tx(d_tx), .vld_tx(vld_tx), .rdy_tx(rdy_tx), .cpu(cpu), .mem(mem), .addr(addr),
        .clk_cpu(clk_cpu));

    // processor model
    always @(posedge clk) if (!rstn) cpu_pc <= 32'h0;
    always @(posedge clk_cpu) if (rstn) cpu_pc <= cpu_pc + 32'd4;
    assign cpu = {cpu_pc, cpu_pc ^ 32'hA5A5_0000};

    assign mem = {addr ^ 32'h1234_5678, addr + 32'h100, addr * 32'd3};   // dm, im, rf

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ TAPS) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = 32'h0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic string hex_word(input logic [31:0] w);
        string s;
        s = $sformatf("%08h", w);
        return s.toupper();
    endfunction

    function automatic string digit_text(input logic [3:0] nib, input logic lower);
        logic [7:0] c;
        if (nib < 4'd10)
            c = 8'h30 + nib;
        else if (lower)
            c = 8'h61 + nib - 8'd10;
        else
            c = 8'h41 + nib - 8'd10;
        return $sformatf("%c", c);
    endfunction

    task automatic check_line(input string name, input string exp, input string act);
        n_checks++;
        if (exp != act) begin
            n_errors++;
            $display("** Error %s: expected \"%s\", actual \"%s\"", name, exp, act);
        end
    endtask

    task automatic expect_line(input string name, input string text);
        name_q.push_back(name);
        exp_q.push_back(text);
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [31:0] gap;
        gap = 32'h0;
        if (stall_en)
            take_bits(2, gap);
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        d_rx   = b;
        vld_rx = 1'b1;
        @(posedge clk);
        while (!rdy_rx)
            @(posedge clk);
        #1;
        vld_rx = 1'b0;
        d_rx   = 8'h00;
    endtask

    task automatic send_text(input string s);
        for (int i = 0; i < s.len(); i++)
            send_byte(s[i]);
    endtask

    // letter, 0-3 spaces, 1-8 digits of mixed case, newline
    task automatic read_cmd(input logic [7:0] letter, input logic bad);
        logic [31:0] r, a, w;
        int          n;
        int          bad_pos;
        string       txt;
        take_bits(3, r);
        n = r + 1;
        take_bits(2, r);
        txt = $sformatf("%c", letter);
        repeat (r) txt = {txt, " "};
        bad_pos = -1;
        if (bad) begin
            take_bits(3, r);
            bad_pos = r % n;
        end
        a = 32'h0;
        for (int i = 0; i < n; i++) begin
            take_bits(5, r);
            a = {a[27:0], r[3:0]};
            txt = {txt, digit_text(r[3:0], r[4])};
            if (i == bad_pos)
                txt = {txt, "G"};
        end
        case (letter)
            CMD_I:   w = a + 32'h100;
            CMD_R:   w = a * 32'd3;
            default: w = a ^ 32'h1234_5678;
        endcase
        if (bad)
            expect_line($sformatf("%s %c", test_name, letter), "?");
        else
            expect_line($sformatf("%s %c", test_name, letter), hex_word(w));
        send_text({txt, "\n"});
    endtask

    task automatic pc_cmd(input logic t);
        if (t) begin
            exp_pc = exp_pc + 32'd4;
            expect_line({test_name, " T"}, hex_word(exp_pc));
            send_text("T\n");
        end else begin
            expect_line({test_name, " P pc"}, hex_word(exp_pc));
            expect_line({test_name, " P ir"}, hex_word(exp_pc ^ 32'hA5A5_0000));
            send_text("P\n");
        end
    endtask

    task automatic reject_cmd();
        logic [31:0] r;
        logic [7:0]  letter;
        take_bits(2, r);
        letter = 8'h55 + r[7:0];   // U to X
        expect_line($sformatf("%s %c", test_name, letter), "?");
        send_text($sformatf("%c\n", letter));
    endtask

    task automatic random_cmd();
        logic [31:0] r;
        take_bits(3, r);
        case (r[2:0])
            3'd1:    read_cmd(CMD_I, 1'b0);
            3'd2:    read_cmd(CMD_R, 1'b0);
            3'd3:    pc_cmd(1'b0);
            3'd4:    pc_cmd(1'b1);
            3'd5:    reject_cmd();
            3'd6:    read_cmd(CMD_D, 1'b1);
            default: read_cmd(CMD_D, 1'b0);
        endcase
    endtask

    task automatic start_test(input string name);
        test_name = name;
        chk0      = n_checks;
        err0      = n_errors;
    endtask

    task automatic end_test();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        // stray bytes after the last reply show up here
        repeat (DRAIN_CYCLES) @(posedge clk);
        #1;
        if (line != "") begin
            n_errors++;
            $display("test %s left extra reply bytes \"%s\"", test_name, line);
            line = "";
        end
        $display("test %-8s %0d lines checked, %0d errors", test_name,
            n_checks - chk0, n_errors - err0);
    endtask

    // reply collector
    always @(posedge clk) begin
        if (rstn && vld_tx && rdy_tx) begin
            if (d_tx != CHR_NL) begin
                line = $sformatf("%s%c", line, d_tx);
            end else if (exp_q.size() == 0) begin
                n_errors++;
                $display("reply line \"%s\" arrived with no command pending", line);
                line = "";
            end else begin
                check_line(name_q.pop_front(), exp_q.pop_front(), line);
                line = "";
            end
        end
    end

    // draws at the falling edge so they never meet the driver's draws
    always begin
        @(negedge clk);
        stall_r = 32'h1;
        if (stall_en)
            take_bits(2, stall_r);
        @(posedge clk);
        #1 rdy_tx = (stall_r[1:0] != 2'b00);   // low one cycle in four
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d replies outstanding", cycles, exp_q.size());
        $display("Result: FAILED");
        $finish;
    end

    initial begin : main
        logic [31:0] r;
        d_rx     = 8'h00;
        vld_rx   = 1'b0;
        rdy_tx   = 1'b1;
        stall_en = 1'b0;
        lfsr     = SEED;
        exp_pc   = 32'h0;
        @(posedge clk);
        while (!rstn)
            @(posedge clk);
        #1;

        start_test("mem_read");
        repeat (15) begin
            take_bits(2, r);
            read_cmd((r == 1) ? CMD_I : (r == 2) ? CMD_R : CMD_D, 1'b0);
        end
        end_test();

        start_test("pc_ir");
        pc_cmd(1'b0);
        pc_cmd(1'b0);
        end_test();

        start_test("step");
        repeat (4) pc_cmd(1'b1);
        pc_cmd(1'b0);
        pc_cmd(1'b1);
        end_test();

        start_test("reject");
        reject_cmd();
        read_cmd(CMD_D, 1'b1);
        reject_cmd();
        read_cmd(CMD_D, 1'b1);
        end_test();

        start_test("stress");
        stall_en = 1'b1;
        repeat (40) random_cmd();
        end_test();
        stall_en = 1'b0;

        $display("lines checked %0d, errors %0d, cycles %0d", n_checks, n_errors, cycles);
        if (n_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

/* project.f */
hw/dcp_cmd_pkg.sv
hw/dcp_cpu_pkg.sv
hw/dcp_scan.sv
hw/dcp_print.sv
hw/dcp_ctrl.sv
hw/dcp_cmd_mem.sv
hw/dcp_cmd_step.sv
hw/dcp_top.sv
test/tb_clkgen.sv
test/tb_dcp.sv
